//--- Makefile
# Verilator build and run for the lane highlight testbench

SOURCES := $(wildcard common/*.sv common/*.svh hdl/*.sv lane_tracer/*.sv verification/*.sv)

.PHONY: all run clean

all: run

# The binary is rebuilt only when a source or the file list changes
obj_dir/Vlane_highlight_tb: lane_highlight_top.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module lane_highlight_tb -f lane_highlight_top.f

run: obj_dir/Vlane_highlight_tb
	./obj_dir/Vlane_highlight_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- common/highlight_settings.svh
`ifndef HIGHLIGHT_SETTINGS_SVH
`define HIGHLIGHT_SETTINGS_SVH

`default_nettype none

// Frame size of the external image store in pixels
`define IMAGE_WIDTH 64
`define IMAGE_HEIGHT 48

// The lane mask covers only part of the frame, starting at this corner
`define MASK_X0 8
`define MASK_Y0 16
`define MASK_WIDTH 48
`define MASK_HEIGHT 24

// Range of the line parameter k, so each lane is drawn from K_START to K_END - 1
`define K_START (-40)
`define K_END 40

// Half-width of a highlighted lane, so a point becomes 2 * OFFSET + 1 pixels wide
`define OFFSET 2

// Number of lanes the Hough stage reports per frame
`define LANES 2

// Mask bytes at or above this level are treated as lane pixels
`define MASK_THRESHOLD 8'h0F

// Fraction bits of the quantized sine and cosine tables
`define TRIG_FRAC_BITS 8

`default_nettype wire

`endif

//--- common/image_bus_pkg.sv
`default_nettype none

package image_bus_pkg;

    // One image pixel, three 8-bit colour channels
    typedef logic [23:0] pixel_t;

    // Word address into the frame store, one word per pixel
    typedef logic [11:0] image_addr_t;

    // Byte lanes of one pixel word on the Wishbone bus
    typedef logic [2:0] image_sel_t;

    // Byte address into the lane mask window
    typedef logic [10:0] mask_addr_t;

    // Red only, with red held in the low byte of the pixel word
    localparam pixel_t HIGHLIGHT_COLOR = 24'h0000FF;

endpackage

`default_nettype wire

//--- common/lane_geometry_pkg.sv
`include "highlight_settings.svh"

`default_nettype none

package lane_geometry_pkg;

    // Line distance from the origin as reported by the Hough stage
    typedef logic signed [15:0] rho_t;

    // Angle index, one of sixteen steps over half a turn
    typedef logic [3:0] theta_t;

    // Pixel coordinate, signed so that points left of or above the frame stay visible
    typedef logic signed [11:0] coord_t;

    // Position along the line
    typedef logic signed [7:0] k_t;

    // Quantized trig value with TRIG_FRAC_BITS fraction bits
    typedef logic signed [11:0] trig_t;

    localparam int THETA_STEPS = 16;

    // Entry i holds sin(i * 11.25 degrees) scaled by 256
    localparam trig_t sin_table [THETA_STEPS] = '{
        12'sd0,   12'sd50,  12'sd98,  12'sd142,
        12'sd181, 12'sd213, 12'sd237, 12'sd251,
        12'sd256, 12'sd251, 12'sd237, 12'sd213,
        12'sd181, 12'sd142, 12'sd98,  12'sd50
    };

    // Entry i holds cos(i * 11.25 degrees) scaled by 256
    localparam trig_t cos_table [THETA_STEPS] = '{
        12'sd256,  12'sd251,  12'sd237,  12'sd213,
        12'sd181,  12'sd142,  12'sd98,   12'sd50,
        12'sd0,    -12'sd50,  -12'sd98,  -12'sd142,
        -12'sd181, -12'sd213, -12'sd237, -12'sd251
    };

    // Removes the trig fraction bits and rounds toward zero
    function automatic coord_t dequantize(input logic signed [31:0] value);
        logic signed [31:0] magnitude;
        // A plain arithmetic shift would round negative values down, so the
        // shift is done on the magnitude and the sign is put back afterwards
        if (value < 0) begin
            magnitude = -value;
            return coord_t'(-(magnitude >>> `TRIG_FRAC_BITS));
        end
        return coord_t'(value >>> `TRIG_FRAC_BITS);
    endfunction

endpackage

`default_nettype wire

//--- hdl/lane_dispatcher.sv
`timescale 1ns/1ps

`include "highlight_settings.svh"

`default_nettype none

module lane_dispatcher
    import lane_geometry_pkg::*;
(
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                hough_done,
    input  logic [`LANES*$bits(rho_t)-1:0]      lane_rho,
    input  logic [`LANES*$bits(theta_t)-1:0]    lane_theta,
    input  logic [`LANES-1:0]                   lane_done,
    output logic [`LANES-1:0]                   lane_start,
    output logic [`LANES*$bits(rho_t)-1:0]      start_rho,
    output logic [`LANES*$bits(theta_t)-1:0]    start_theta,
    output logic                                highlight_done
);

    // High from the accepted hough_done until the completion pulse
    logic busy;

    // One bit per lane that has already reported its last point
    logic [`LANES-1:0] done_mask;
    logic [`LANES-1:0] done_next;

    // Lanes may finish in the same cycle, so new done pulses are merged first
    assign done_next = done_mask | lane_done;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            lane_start <= '0;
            done_mask <= '0;
            highlight_done <= 1'b0;
        end else begin
            lane_start <= '0;
            highlight_done <= 1'b0;
            if (!busy) begin
                // A new frame starts every tracer together, one cycle after hough_done
                if (hough_done) begin
                    busy <= 1'b1;
                    lane_start <= '1;
                    done_mask <= '0;
                end
            end else begin
                done_mask <= done_next;
                // The frame is over once every lane has reported
                if (&done_next) begin
                    busy <= 1'b0;
                    highlight_done <= 1'b1;
                    done_mask <= '0;
                end
            end
        end
    end

    // The Hough side may move on to the next frame, so the lane
    // parameters are held here for as long as the tracers need them
    always_ff @(posedge clock) begin
        if (!busy && hough_done) begin
            start_rho <= lane_rho;
            start_theta <= lane_theta;
        end
    end

endmodule

`default_nettype wire

//--- hdl/lane_highlight_top.sv
`timescale 1ns/1ps

`include "highlight_settings.svh"

`default_nettype none

module lane_highlight_top
    import lane_geometry_pkg::*, image_bus_pkg::*;
(
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    hough_done,
    input  logic [`LANES*$bits(rho_t)-1:0]          lane_rho,
    input  logic [`LANES*$bits(theta_t)-1:0]        lane_theta,
    input  logic [`LANES*8-1:0]                     mask_rd_data,
    output logic [`LANES*$bits(mask_addr_t)-1:0]    mask_rd_addr,
    input  logic                                    wb_ack,
    output logic                                    wb_cyc,
    output logic                                    wb_stb,
    output logic                                    wb_we,
    output image_addr_t                             wb_adr,
    output pixel_t                                  wb_dat_w,
    output image_sel_t                              wb_sel,
    output logic                                    highlight_done
);

    // Frame start and end between the dispatcher and the tracers
    logic [`LANES-1:0]                  lane_start;
    logic [`LANES-1:0]                  lane_done;
    logic [`LANES*$bits(rho_t)-1:0]     start_rho;
    logic [`LANES*$bits(theta_t)-1:0]   start_theta;

    // Pixel write requests from the tracers, one slice per lane
    logic [`LANES-1:0]                      wr_req;
    logic [`LANES-1:0]                      wr_grant;
    logic [`LANES*$bits(image_addr_t)-1:0]  wr_addr;
    logic [`LANES*$bits(pixel_t)-1:0]       wr_data;

    lane_dispatcher u_dispatcher (
        .clock          (clock),
        .reset          (reset),
        .hough_done     (hough_done),
        .lane_rho       (lane_rho),
        .lane_theta     (lane_theta),
        .lane_done      (lane_done),
        .lane_start     (lane_start),
        .start_rho      (start_rho),
        .start_theta    (start_theta),
        .highlight_done (highlight_done)
    );

    // Each lane has its own mask port, so all lanes trace at the same time
    for (genvar lane = 0; lane < `LANES; lane++) begin : tracer_slice
        lane_tracer u_tracer (
            .clock        (clock),
            .reset        (reset),
            .lane_start   (lane_start[lane]),
            .rho          (start_rho[lane*$bits(rho_t) +: $bits(rho_t)]),
            .theta        (start_theta[lane*$bits(theta_t) +: $bits(theta_t)]),
            .mask_rd_data (mask_rd_data[lane*8 +: 8]),
            .wr_grant     (wr_grant[lane]),
            .mask_rd_addr (mask_rd_addr[lane*$bits(mask_addr_t) +: $bits(mask_addr_t)]),
            .wr_req       (wr_req[lane]),
            .wr_addr      (wr_addr[lane*$bits(image_addr_t) +: $bits(image_addr_t)]),
            .wr_data      (wr_data[lane*$bits(pixel_t) +: $bits(pixel_t)]),
            .lane_done    (lane_done[lane])
        );
    end

    // The frame store has one write port, so the lanes share it in turn
    wb_write_arbiter u_arbiter (
        .clock    (clock),
        .reset    (reset),
        .wr_req   (wr_req),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wb_ack   (wb_ack),
        .wr_grant (wr_grant),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel)
    );

endmodule

`default_nettype wire

//--- hdl/wb_write_arbiter.sv
`timescale 1ns/1ps

`include "highlight_settings.svh"

`default_nettype none

module wb_write_arbiter
    import image_bus_pkg::*;
(
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic [`LANES-1:0]                       wr_req,
    input  logic [`LANES*$bits(image_addr_t)-1:0]   wr_addr,
    input  logic [`LANES*$bits(pixel_t)-1:0]        wr_data,
    input  logic                                    wb_ack,
    output logic [`LANES-1:0]                       wr_grant,
    output logic                                    wb_cyc,
    output logic                                    wb_stb,
    output logic                                    wb_we,
    output image_addr_t                             wb_adr,
    output pixel_t                                  wb_dat_w,
    output image_sel_t                              wb_sel
);

    localparam int IDX_W = (`LANES > 1) ? $clog2(`LANES) : 1;

    // Lane that gets first look in the next arbitration
    logic [IDX_W-1:0] rr_ptr;

    // Lane that owns the bus cycle in progress
    logic [IDX_W-1:0] owner;

    logic             found;
    logic [IDX_W-1:0] winner;

    // Search starts at the pointer and wraps, so each lane waits at most one round
    always_comb begin
        int idx;
        found = 1'b0;
        winner = rr_ptr;
        for (int i = 0; i < `LANES; i++) begin
            idx = (int'(rr_ptr) + i) % `LANES;
            if (!found && wr_req[idx]) begin
                found = 1'b1;
                winner = IDX_W'(idx);
            end
        end
    end

    // The owner learns in the ack cycle that its pixel has been written
    always_comb begin
        for (int i = 0; i < `LANES; i++) begin
            wr_grant[i] = wb_cyc && wb_ack && (int'(owner) == i);
        end
    end

    // Classic single writes, so strobe follows the cycle and all bytes are written
    assign wb_stb = wb_cyc;
    assign wb_we = wb_cyc;
    assign wb_sel = {$bits(image_sel_t){wb_cyc}};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wb_cyc <= 1'b0;
            rr_ptr <= '0;
            owner <= '0;
        end else begin
            if (!wb_cyc) begin
                if (found) begin
                    wb_cyc <= 1'b1;
                    owner <= winner;
                end
            end else if (wb_ack) begin
                // The bus goes idle for a cycle so the lanes can update their requests
                wb_cyc <= 1'b0;
                rr_ptr <= IDX_W'((int'(owner) + 1) % `LANES);
            end
        end
    end

    // Address and data are copied once, so they stay fixed until the ack
    always_ff @(posedge clock) begin
        if (!wb_cyc && found) begin
            wb_adr <= wr_addr[winner*$bits(image_addr_t) +: $bits(image_addr_t)];
            wb_dat_w <= wr_data[winner*$bits(pixel_t) +: $bits(pixel_t)];
        end
    end

endmodule

`default_nettype wire

//--- lane_highlight_top.f
+incdir+common
common/lane_geometry_pkg.sv
common/image_bus_pkg.sv
hdl/lane_dispatcher.sv
lane_tracer/lane_tracer.sv
hdl/wb_write_arbiter.sv
hdl/lane_highlight_top.sv
verification/lane_highlight_properties.sv
verification/lane_highlight_tb.sv

//--- lane_tracer/lane_tracer.sv
`timescale 1ns/1ps

`include "highlight_settings.svh"

`default_nettype none

module lane_tracer
    import lane_geometry_pkg::*, image_bus_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        lane_start,
    input  rho_t        rho,
    input  theta_t      theta,
    input  logic [7:0]  mask_rd_data,
    input  logic        wr_grant,
    output mask_addr_t  mask_rd_addr,
    output logic        wr_req,
    output image_addr_t wr_addr,
    output pixel_t      wr_data,
    output logic        lane_done
);

    // POINT computes one point per k, MASK checks it, PIXEL draws it
    typedef enum logic [1:0] {
        IDLE,
        POINT,
        MASK,
        PIXEL
    } state_t;

    state_t state;

    // Line parameters of the current lane
    rho_t  rho_q;
    trig_t sin_q;
    trig_t cos_q;

    // Position along the line
    k_t k;
    logic k_done;

    // Point of the current k, combinational and then registered
    coord_t x_calc;
    coord_t y_calc;
    coord_t x;
    coord_t y;
    logic   in_window;

    // Column being written in PIXEL, walks from x - OFFSET to x + OFFSET
    coord_t pix_x;
    logic   pix_in_image;
    logic   pix_last;
    logic   pix_step;

    always_comb begin
        // Point on the line x = rho*cos - k*sin and y = rho*sin + k*cos
        x_calc = dequantize(rho_q * cos_q - k * sin_q);
        y_calc = dequantize(rho_q * sin_q + k * cos_q);

        in_window = (x_calc >= `MASK_X0) && (x_calc < `MASK_X0 + `MASK_WIDTH) &&
                    (y_calc >= `MASK_Y0) && (y_calc < `MASK_Y0 + `MASK_HEIGHT);

        // The mask port answers one cycle later, which is exactly the MASK state.
        // Outside the window the address is meaningless and the answer is never used
        mask_rd_addr = mask_addr_t'((int'(y_calc) - `MASK_Y0) * `MASK_WIDTH +
                                    int'(x_calc) - `MASK_X0);

        k_done = k >= `K_END;
    end

    always_comb begin
        // Columns left or right of the frame are skipped without a bus write
        pix_in_image = (pix_x >= 0) && (pix_x < `IMAGE_WIDTH);
        pix_last = pix_x == x + coord_t'(`OFFSET);

        // The column may move on once it is skipped or its write was granted
        pix_step = !pix_in_image || wr_grant;

        // The request stays up with the same address until the grant
        wr_req = (state == PIXEL) && pix_in_image;
        wr_addr = image_addr_t'(int'(y) * `IMAGE_WIDTH + int'(pix_x));
        wr_data = HIGHLIGHT_COLOR;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            k <= '0;
            lane_done <= 1'b0;
        end else begin
            lane_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (lane_start) begin
                        k <= k_t'(`K_START);
                        state <= POINT;
                    end
                end

                POINT: begin
                    if (k_done) begin
                        lane_done <= 1'b1;
                        state <= IDLE;
                    end else if (in_window) begin
                        state <= MASK;
                    end else begin
                        // Points outside the window cost one cycle and no mask read
                        k <= k + 1'b1;
                    end
                end

                MASK: begin
                    if (mask_rd_data >= `MASK_THRESHOLD) begin
                        state <= PIXEL;
                    end else begin
                        k <= k + 1'b1;
                        state <= POINT;
                    end
                end

                PIXEL: begin
                    if (pix_step && pix_last) begin
                        k <= k + 1'b1;
                        state <= POINT;
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        // Trig values are looked up once per lane and not once per point
        if (state == IDLE && lane_start) begin
            rho_q <= rho;
            sin_q <= sin_table[theta];
            cos_q <= cos_table[theta];
        end
        if (state == POINT) begin
            x <= x_calc;
            y <= y_calc;
        end
        if (state == MASK) begin
            pix_x <= x - coord_t'(`OFFSET);
        end
        if (state == PIXEL && pix_step) begin
            pix_x <= pix_x + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verification/lane_highlight_properties.sv
`timescale 1ns/1ps

`include "highlight_settings.svh"

`default_nettype none

module lane_highlight_properties
    import image_bus_pkg::*;
(
    input logic        clock,
    input logic        reset,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic        wb_ack,
    input image_addr_t wb_adr,
    input pixel_t      wb_dat_w,
    input logic        highlight_done
);

    // Failed assertions so far, read by the testbench at the end of the run
    int assertion_failures = 0;

    stb_needs_cyc: assert property (@(posedge clock) disable iff (reset) wb_stb |-> wb_cyc)
        else begin
            assertion_failures++;
            $error("wb_stb is high while wb_cyc is low");
        end

    // A waiting master keeps its address and data until the slave acks
    held_until_ack: assert property (@(posedge clock) disable iff (reset)
        (wb_cyc && !wb_ack) |=> (wb_cyc && $stable(wb_adr) && $stable(wb_dat_w)))
        else begin
            assertion_failures++;
            $error("wb_adr or wb_dat_w changed before wb_ack");
        end

    adr_in_frame: assert property (@(posedge clock) disable iff (reset)
        wb_cyc |-> (wb_adr < `IMAGE_WIDTH * `IMAGE_HEIGHT))
        else begin
            assertion_failures++;
            $error("wb_adr %0h lies outside the frame", wb_adr);
        end

    // The frame may only be reported complete once the bus is idle
    done_after_bus: assert property (@(posedge clock) disable iff (reset)
        highlight_done |-> !wb_cyc)
        else begin
            assertion_failures++;
            $error("highlight_done is high during a bus cycle");
        end

endmodule

`default_nettype wire

//--- verification/lane_highlight_tb.sv
`timescale 1ns/1ps

`include "highlight_settings.svh"

`default_nettype none

module lane_highlight_tb
    import lane_geometry_pkg::*, image_bus_pkg::*;
();

    localparam int MASK_BYTES = `MASK_WIDTH * `MASK_HEIGHT;
    localparam int FRAMES = 8;

    logic clock;
    logic reset;
    logic hough_done;
    logic [`LANES*$bits(rho_t)-1:0]       lane_rho;
    logic [`LANES*$bits(theta_t)-1:0]     lane_theta;
    logic [`LANES*8-1:0]                  mask_rd_data = '0;
    logic [`LANES*$bits(mask_addr_t)-1:0] mask_rd_addr;
    logic [`LANES*$bits(mask_addr_t)-1:0] mask_addr_q;
    logic        wb_ack = 1'b0;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    image_addr_t wb_adr;
    pixel_t      wb_dat_w;
    image_sel_t  wb_sel;
    logic        highlight_done;

    // Mask window contents and per-address write counts of the current frame
    logic [7:0] mask_mem [MASK_BYTES];
    integer exp_count [4096];
    integer act_count [4096];
    integer sin_q [16];
    integer cos_q [16];
    integer frame_rho [`LANES];
    integer frame_theta [`LANES];

    integer seed = 1751;
    integer ack_wait = -1;
    integer exp_total;
    integer frame_writes;
    integer done_pulses;
    integer mismatches = 0;
    integer failures = 0;
    integer frame;
    logic   timed_out = 1'b0;

    lane_highlight_top DUT (
        .clock          (clock),
        .reset          (reset),
        .hough_done     (hough_done),
        .lane_rho       (lane_rho),
        .lane_theta     (lane_theta),
        .mask_rd_data   (mask_rd_data),
        .mask_rd_addr   (mask_rd_addr),
        .wb_ack         (wb_ack),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_sel         (wb_sel),
        .highlight_done (highlight_done)
    );

    bind lane_highlight_top lane_highlight_properties u_properties (
        .clock          (clock),
        .reset          (reset),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_ack         (wb_ack),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .highlight_done (highlight_done)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;

    // Trig entry for angle index i, i * 11.25 degrees scaled by 256 and rounded
    function automatic integer trig_value(input integer index, input bit use_cos);
        real angle;
        real scaled;
        angle = index * 3.14159265358979 / 16.0;
        scaled = (use_cos ? $cos(angle) : $sin(angle)) * 256.0;
        if (scaled >= 0.0) return $rtoi(scaled + 0.5);
        return -$rtoi(0.5 - scaled);
    endfunction

    function automatic logic [7:0] mask_byte(input integer addr);
        if (addr < MASK_BYTES) return mask_mem[addr];
        return 8'h00;
    endfunction

    task automatic report_mismatch(input string name, input integer expected,
                                   input integer actual);
        $display("mismatch %s expected %0h actual %0h", name, expected, actual);
        mismatches = mismatches + 1;
    endtask

    // Expected writes of one frame, straight from the trace rule
    task automatic build_expected();
        integer x;
        integer y;
        integer px;
        exp_total = 0;
        for (int a = 0; a < 4096; a++) begin
            exp_count[a] = 0;
        end
        for (int lane = 0; lane < `LANES; lane++) begin
            for (int k = `K_START; k < `K_END; k++) begin
                // Integer division truncates toward zero, as the dequantize rule asks
                x = (frame_rho[lane] * cos_q[frame_theta[lane]] - k * sin_q[frame_theta[lane]])
                    / (1 << `TRIG_FRAC_BITS);
                y = (frame_rho[lane] * sin_q[frame_theta[lane]] + k * cos_q[frame_theta[lane]])
                    / (1 << `TRIG_FRAC_BITS);
                if (x >= `MASK_X0 && x < `MASK_X0 + `MASK_WIDTH &&
                    y >= `MASK_Y0 && y < `MASK_Y0 + `MASK_HEIGHT &&
                    mask_mem[(y - `MASK_Y0) * `MASK_WIDTH + x - `MASK_X0] >= `MASK_THRESHOLD) begin
                    for (px = x - `OFFSET; px <= x + `OFFSET; px++) begin
                        if (px >= 0 && px < `IMAGE_WIDTH) begin
                            exp_count[y * `IMAGE_WIDTH + px]++;
                            exp_total++;
                        end
                    end
                end
            end
        end
    endtask

    // Mask port with one cycle of read latency, the address is taken mid-cycle
    always @(negedge clock) mask_addr_q <= mask_rd_addr;

    always @(posedge clock) begin
        #1;
        for (int lane = 0; lane < `LANES; lane++) begin
            mask_rd_data[lane*8 +: 8] = mask_byte(mask_addr_q[lane*11 +: 11]);
        end
    end

    // Image store slave, acks each write after 0 to 3 wait cycles
    always @(posedge clock) begin
        #1;
        if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (ack_wait < 0) ack_wait = $unsigned($random(seed)) % 4;
            if (ack_wait == 0) begin
                wb_ack = 1'b1;
                ack_wait = -1;
            end else begin
                ack_wait = ack_wait - 1;
            end
        end
    end

    task automatic record_write();
        if (wb_we !== 1'b1) report_mismatch("write_enable", 1, wb_we);
        if (wb_sel !== 3'b111) report_mismatch("byte_select", 3'b111, wb_sel);
        if (wb_dat_w !== HIGHLIGHT_COLOR) report_mismatch("pixel_data", HIGHLIGHT_COLOR, wb_dat_w);
        if (exp_count[wb_adr] == 0) begin
            $display("write to address %0h that no lane should draw in frame %0d", wb_adr, frame);
            failures = failures + 1;
        end
        act_count[wb_adr]++;
        frame_writes++;
    endtask

    // Bus and done outputs are looked at mid-cycle, where they are settled
    always @(negedge clock) begin
        if (!reset && highlight_done) done_pulses = done_pulses + 1;
        if (!reset && wb_cyc && wb_stb && wb_ack) record_write();
    end

    task automatic run_frame(input integer index);
        integer cycles;
        integer writes_at_done;
        logic [`LANES*$bits(rho_t)-1:0] busy_rho;
        // Frame 5 has an empty mask, every other frame a random one
        for (int a = 0; a < MASK_BYTES; a++) begin
            mask_mem[a] = (index == 5) ? 8'h00 : 8'($unsigned($random(seed)) % 32);
        end
        for (int lane = 0; lane < `LANES; lane++) begin
            frame_rho[lane] = integer'($unsigned($random(seed)) % 96) - 16;
            frame_theta[lane] = $unsigned($random(seed)) % 16;
            // Frame 2 puts vertical lines left and right of the mask window
            if (index == 2) begin
                frame_rho[lane] = (lane == 0) ? 100 : -30;
                frame_theta[lane] = 0;
            end
        end
        busy_rho = $random(seed);
        build_expected();
        for (int a = 0; a < 4096; a++) begin
            act_count[a] = 0;
        end
        frame_writes = 0;
        done_pulses = 0;

        @(posedge clock);
        #1;
        hough_done = 1'b1;
        for (int lane = 0; lane < `LANES; lane++) begin
            lane_rho[lane*$bits(rho_t) +: $bits(rho_t)] = rho_t'(frame_rho[lane]);
            lane_theta[lane*$bits(theta_t) +: $bits(theta_t)] = theta_t'(frame_theta[lane]);
        end
        @(posedge clock);
        #1;
        hough_done = 1'b0;
        // A second pulse with other parameters arrives while the frame is busy
        repeat (3) @(posedge clock);
        #1;
        hough_done = 1'b1;
        lane_rho = busy_rho;
        @(posedge clock);
        #1;
        hough_done = 1'b0;

        cycles = 0;
        while (done_pulses == 0 && cycles < 20000) begin
            @(posedge clock);
            #1;
            cycles++;
        end
        if (done_pulses == 0) begin
            $display("highlight_done never came in frame %0d", index);
            timed_out = 1'b1;
            return;
        end
        writes_at_done = frame_writes;
        repeat (20) @(posedge clock);
        #1;

        if (done_pulses != 1) report_mismatch("done_pulses", 1, done_pulses);
        if (frame_writes != writes_at_done) begin
            $display("writes came after highlight_done in frame %0d", index);
            failures = failures + 1;
        end
        if (frame_writes != exp_total) report_mismatch("frame_writes", exp_total, frame_writes);
        if ((index == 2 || index == 5) && frame_writes != 0) begin
            report_mismatch("empty_frame_writes", 0, frame_writes);
        end
        for (int a = 0; a < 4096; a++) begin
            if (act_count[a] != exp_count[a]) begin
                report_mismatch($sformatf("count_at_%0h", a), exp_count[a], act_count[a]);
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        hough_done = 1'b0;
        lane_rho = '0;
        lane_theta = '0;
        exp_total = 0;
        frame_writes = 0;
        done_pulses = 0;
        for (int i = 0; i < 16; i++) begin
            sin_q[i] = trig_value(i, 1'b0);
            cos_q[i] = trig_value(i, 1'b1);
        end

        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;
        repeat (3) @(posedge clock);
        #1;
        if (wb_cyc !== 1'b0) report_mismatch("reset_wb_cyc", 0, wb_cyc);
        if (wb_stb !== 1'b0) report_mismatch("reset_wb_stb", 0, wb_stb);
        if (highlight_done !== 1'b0) report_mismatch("reset_highlight_done", 0, highlight_done);

        for (frame = 0; frame < FRAMES; frame++) begin
            run_frame(frame);
            if (timed_out) break;
        end

        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, DUT.u_properties.assertion_failures);
        if (mismatches == 0 && failures == 0 && !timed_out &&
            DUT.u_properties.assertion_failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
